// ==== udp_rx_top.f ====
rtl/udp_rx_pkg.sv
rtl/rx_byte_if.sv
rtl/rx_parse_if.sv
rtl/gmii_rx_align.sv
rtl/udp_hdr_parser.sv
rtl/udp_rx_output.sv
rtl/udp_rx_top.sv
test/tb_clk_gen.sv
test/udp_rx_monitor.sv
test/udp_rx_asserts.sv
test/udp_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module udp_rx_tb -Mdir obj_dir -f udp_rx_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vudp_rx_tb +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== test/udp_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_tb;

  localparam logic [47:0] LOCAL_MAC  = 48'h02_00_00_00_00_01;
  localparam logic [31:0] LOCAL_IP   = 32'hC0A8_0001;
  localparam logic [15:0] LOCAL_PORT = 16'd1234;
  localparam int          MIN_FRAME  = 60;   // without fcs
  localparam int          GAP        = 12;
  localparam int          WAIT_MAX   = 16;
  localparam int          N_ROWS     = 11;

  // injected faults
  localparam logic [3:0] F_NONE = 4'd0;
  localparam logic [3:0] F_MAC = 4'd1;
  localparam logic [3:0] F_ETYPE = 4'd2;
  localparam logic [3:0] F_IP = 4'd3;
  localparam logic [3:0] F_PORT = 4'd4;
  localparam logic [3:0] F_CSUM = 4'd5;
  localparam logic [3:0] F_FCS = 4'd6;
  localparam logic [3:0] F_SHORT_PRE = 4'd7;

  typedef struct packed {
    logic       bcast;
    logic [7:0] plen;
    logic [3:0] fault;
    logic       exp_acc;
    logic       exp_err;
  } row_t;

  logic        gmii_rx_clk;
  logic        rst_n;
  logic        gmii_rxdv;
  logic [7:0]  gmii_rxd;
  logic [47:0] local_mac;
  logic [31:0] local_ip;
  logic [15:0] local_port;
  logic [7:0]  payload_data;
  logic        payload_valid;
  logic        pkt_done;
  logic        pkt_error;
  logic [47:0] src_mac;
  logic [31:0] src_ip;
  logic [15:0] src_port;
  logic [15:0] payload_len;

  row_t        tbl [N_ROWS];
  logic [7:0]  frame_q [$];   // bytes after the sfd including the fcs
  logic [15:0] lfsr_state;

  tb_clk_gen u_clk (.gmii_rx_clk(gmii_rx_clk), .rst_n(rst_n));

  udp_rx_top dut (
    .gmii_rx_clk     (gmii_rx_clk),
    .rst_n           (rst_n),
    .gmii_rxdv_i     (gmii_rxdv),
    .gmii_rxd_i      (gmii_rxd),
    .local_mac_i     (local_mac),
    .local_ip_i      (local_ip),
    .local_port_i    (local_port),
    .payload_data_o  (payload_data),
    .payload_valid_o (payload_valid),
    .pkt_done_o      (pkt_done),
    .pkt_error_o     (pkt_error),
    .src_mac_o       (src_mac),
    .src_ip_o        (src_ip),
    .src_port_o      (src_port),
    .payload_len_o   (payload_len)
  );

  udp_rx_monitor mon (
    .gmii_rx_clk     (gmii_rx_clk),
    .rst_n           (rst_n),
    .payload_data_i  (payload_data),
    .payload_valid_i (payload_valid),
    .pkt_done_i      (pkt_done),
    .pkt_error_i     (pkt_error),
    .src_mac_i       (src_mac),
    .src_ip_i        (src_ip),
    .src_port_i      (src_port),
    .payload_len_i   (payload_len)
  );

  // ------------------------------------------------------------------
  // reference helpers
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois lfsr for x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int k = 0; k < 8; k++) begin
      b[k] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
    return b;
  endfunction

  function automatic logic [15:0] ip_checksum(input udp_rx_pkg::ip_hdr_u h);
    logic [31:0] s;
    s = '0;
    for (int k = 0; k < 10; k++) begin
      s = s + {16'd0, h.words[k]};
    end
    s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
    s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
    return ~s[15:0];
  endfunction

  // reflected ethernet fcs sent low byte first
  function automatic logic [31:0] eth_fcs();
    logic [31:0] c;
    c = '1;
    foreach (frame_q[i]) begin
      c = c ^ {24'd0, frame_q[i]};
      for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic push_field(input logic [47:0] v, input int n);
    for (int i = 0; i < n; i++) begin
      frame_q.push_back(v[8*(n-1-i) +: 8]);   // network order
    end
  endtask

  // ------------------------------------------------------------------
  // frame builder
  task automatic build_frame(input int idx);
    row_t                r;
    udp_rx_pkg::ip_hdr_u hdr;
    logic [47:0]         dst_mac;
    logic [47:0]         s_mac;
    logic [31:0]         s_ip;
    logic [15:0]         s_port;
    logic [31:0]         fcs;
    logic [7:0]          b;
    r      = tbl[idx];
    s_mac  = 48'h02_AA_BB_CC_00_00 + 48'(idx);
    s_ip   = 32'h0A00_0064 + 32'(idx);
    s_port = 16'h8000 + 16'(idx);
    dst_mac = r.bcast ? udp_rx_pkg::BROADCAST_MAC : LOCAL_MAC;
    if (r.fault == F_MAC) dst_mac = dst_mac ^ 48'h0000_0000_0100;
    frame_q.delete();
    push_field(dst_mac, 6);
    push_field(s_mac, 6);
    push_field((r.fault == F_ETYPE) ? 48'h86DD : 48'(udp_rx_pkg::ETH_TYPE_IPV4), 2);
    hdr = '0;
    hdr.fields.version   = udp_rx_pkg::IP_VERSION;
    hdr.fields.ihl       = udp_rx_pkg::IP_IHL;
    hdr.fields.total_len = 16'(udp_rx_pkg::IP_HDR_BYTES + udp_rx_pkg::UDP_HDR_BYTES) +
                           {8'd0, r.plen};
    hdr.fields.ttl       = 8'd64;
    hdr.fields.protocol  = udp_rx_pkg::IP_PROTO_UDP;
    hdr.fields.src_ip    = s_ip;
    hdr.fields.dst_ip    = (r.fault == F_IP) ? (LOCAL_IP ^ 32'h1) : LOCAL_IP;
    hdr.fields.checksum  = ip_checksum(hdr);
    if (r.fault == F_CSUM) hdr.fields.checksum = hdr.fields.checksum ^ 16'h0001;
    for (int i = 0; i < 20; i++) begin
      frame_q.push_back(hdr[159-8*i -: 8]);
    end
    push_field(48'(s_port), 2);
    push_field((r.fault == F_PORT) ? 48'(LOCAL_PORT + 16'd1) : 48'(LOCAL_PORT), 2);
    push_field(48'(16'd8 + {8'd0, r.plen}), 2);
    push_field(48'h0, 2);   // udp checksum unused
    if (r.exp_acc) mon.expect_frame(s_mac, s_ip, s_port, {8'd0, r.plen}, r.exp_err);
    for (int k = 0; k < int'(r.plen); k++) begin
      b = rand_byte();
      frame_q.push_back(b);
      if (r.exp_acc) mon.expect_byte(b);
    end
    while (frame_q.size() < MIN_FRAME) frame_q.push_back(8'h00);   // padding
    fcs = eth_fcs();
    push_field(48'({fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]}), 4);
    if (r.fault == F_FCS) frame_q[frame_q.size()-2] = frame_q[frame_q.size()-2] ^ 8'hFF;
  endtask

  // ------------------------------------------------------------------
  // stimulus
  task automatic drive_byte(input logic [7:0] b);
    @(posedge gmii_rx_clk);
    gmii_rxdv <= 1'b1;
    gmii_rxd  <= b;
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge gmii_rx_clk);
      gmii_rxdv <= 1'b0;
      gmii_rxd  <= 8'h00;
    end
  endtask

  task automatic send_frame(input int n_pre);
    for (int k = 0; k < n_pre; k++) begin
      drive_byte(udp_rx_pkg::PREAMBLE_BYTE);
    end
    drive_byte(udp_rx_pkg::SFD_BYTE);
    foreach (frame_q[k]) begin
      drive_byte(frame_q[k]);
    end
    drive_idle(1);
  endtask

  task automatic run_watchdog(input int limit_ns);
    #(limit_ns);
    $display("Timeout: run did not finish within %0d ns", limit_ns);
    $display("Testbench failed");
    $finish;
  endtask

  initial begin
    int limit_ns;
    int total;
    int waited;
    int assert_fails;
    gmii_rxdv  = 1'b0;
    gmii_rxd   = 8'h00;
    local_mac  = LOCAL_MAC;
    local_ip   = LOCAL_IP;
    local_port = LOCAL_PORT;
    lfsr_state = 16'd8;
    // bcast, payload length, fault, accepted, fcs error
    tbl[0]  = '{1'b0, 8'd32, F_NONE, 1'b1, 1'b0};
    tbl[1]  = '{1'b1, 8'd20, F_NONE, 1'b1, 1'b0};
    tbl[2]  = '{1'b0, 8'd24, F_MAC, 1'b0, 1'b0};
    tbl[3]  = '{1'b0, 8'd24, F_ETYPE, 1'b0, 1'b0};
    tbl[4]  = '{1'b0, 8'd24, F_IP, 1'b0, 1'b0};
    tbl[5]  = '{1'b0, 8'd24, F_PORT, 1'b0, 1'b0};
    tbl[6]  = '{1'b0, 8'd24, F_CSUM, 1'b0, 1'b0};
    tbl[7]  = '{1'b0, 8'd40, F_FCS, 1'b1, 1'b1};
    tbl[8]  = '{1'b0, 8'd5, F_NONE, 1'b1, 1'b0};   // padded
    tbl[9]  = '{1'b0, 8'd16, F_SHORT_PRE, 1'b0, 1'b0};
    tbl[10] = '{1'b0, 8'd28, F_NONE, 1'b1, 1'b0};
    total = 0;
    for (int i = 0; i < N_ROWS; i++) begin
      total += 8 + udp_rx_pkg::PAYLOAD_OFS + 4 + 1 + WAIT_MAX + GAP +
               ((int'(tbl[i].plen) < 18) ? 18 : int'(tbl[i].plen));
    end
    limit_ns = total * 20 * 2 + 2000;
    fork
      run_watchdog(limit_ns);
    join_none
    while (rst_n !== 1'b1) @(posedge gmii_rx_clk);
    drive_idle(4);
    for (int i = 0; i < N_ROWS; i++) begin
      build_frame(i);
      send_frame((tbl[i].fault == F_SHORT_PRE) ? 3 : 7);
      waited = 0;
      while (mon.frames_left() != 0 && waited < WAIT_MAX) begin
        @(negedge gmii_rx_clk);   // monitor has popped by now
        waited++;
      end
      if (mon.frames_left() != 0) mon.flush_missing();
      drive_idle(GAP);
    end
    assert_fails = dut.u_output.u_asserts.fail_cnt;
    mon.close_out(assert_fails);
    if (mon.error_total() == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/udp_rx_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_asserts (
  input wire gmii_rx_clk,
  input wire rst_n,
  input wire payload_valid_i,
  input wire pkt_done_i,
  input wire pkt_error_i
);

  int fail_cnt = 0;   // read by the testbench top at the end

  err_only_with_done: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    pkt_error_i |-> pkt_done_i)
    else begin
      $error("pkt_error_o high without pkt_done_o");
      fail_cnt++;
    end

  done_one_cycle: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    pkt_done_i |=> !pkt_done_i)
    else begin
      $error("pkt_done_o held for more than one cycle");
      fail_cnt++;
    end

  // payload always ends before the fcs, so done never meets a byte
  no_payload_at_done: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
    !(payload_valid_i && pkt_done_i))
    else begin
      $error("payload_valid_o and pkt_done_o high together");
      fail_cnt++;
    end

endmodule

bind udp_rx_output udp_rx_asserts u_asserts (
  .gmii_rx_clk     (gmii_rx_clk),
  .rst_n           (rst_n),
  .payload_valid_i (payload_valid_o),
  .pkt_done_i      (pkt_done_o),
  .pkt_error_i     (pkt_error_o)
);

`default_nettype wire

// ==== test/udp_rx_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_monitor (
  input wire        gmii_rx_clk,
  input wire        rst_n,
  input wire [7:0]  payload_data_i,
  input wire        payload_valid_i,
  input wire        pkt_done_i,
  input wire        pkt_error_i,
  input wire [47:0] src_mac_i,
  input wire [31:0] src_ip_i,
  input wire [15:0] src_port_i,
  input wire [15:0] payload_len_i
);

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
    logic [15:0] len;
    logic        err;
  } frame_rec_t;

  logic [7:0] exp_bytes [$];
  frame_rec_t exp_frames [$];
  frame_rec_t rec;
  logic [7:0] exp_b;
  int         rx_count = 0;   // payload bytes since the last done
  int         mismatch_cnt = 0;
  int         missing_cnt = 0;
  int         unexpected_cnt = 0;

  // ------------------------------------------------------------------
  // expectations handed in by the testbench top
  task automatic expect_frame(input logic [47:0] mac, input logic [31:0] ip,
                              input logic [15:0] port, input logic [15:0] len,
                              input logic err);
    exp_frames.push_back('{mac, ip, port, len, err});
  endtask

  task automatic expect_byte(input logic [7:0] b);
    exp_bytes.push_back(b);
  endtask

  function automatic int frames_left();
    return exp_frames.size();
  endfunction

  function automatic int error_total();
    return mismatch_cnt + missing_cnt + unexpected_cnt;
  endfunction

  task automatic flush_missing();
    $display("Missing frame at %0t: no pkt_done_o for an accepted frame", $time);
    missing_cnt += exp_frames.size();
    exp_frames.delete();
    exp_bytes.delete();
    rx_count = 0;
  endtask

  task automatic check_field(input string what, input logic [47:0] got,
                             input logic [47:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // outputs sampled at the edge, before this edge's updates land
  always @(posedge gmii_rx_clk) begin
    if (rst_n) begin
      if (payload_valid_i) begin
        rx_count++;
        if (exp_bytes.size() == 0) begin
          unexpected_cnt++;
          $display("Unexpected payload byte %h at %0t with no frame expected",
                   payload_data_i, $time);
        end else begin
          exp_b = exp_bytes.pop_front();
          check_field("payload byte", 48'(payload_data_i), 48'(exp_b));
        end
      end
      if (pkt_done_i) begin
        if (exp_frames.size() == 0) begin
          unexpected_cnt++;
          $display("Unexpected pkt_done_o at %0t for a frame that should be dropped", $time);
        end else begin
          rec = exp_frames.pop_front();
          check_field("pkt_error_o", 48'(pkt_error_i), 48'(rec.err));
          check_field("src_mac_o", src_mac_i, rec.mac);
          check_field("src_ip_o", 48'(src_ip_i), 48'(rec.ip));
          check_field("src_port_o", 48'(src_port_i), 48'(rec.port));
          check_field("payload_len_o", 48'(payload_len_i), 48'(rec.len));
          check_field("payload byte count", 48'(rx_count), 48'(rec.len));
        end
        rx_count = 0;
      end
    end
  end

  task automatic close_out(input int assert_fails);
    if (exp_frames.size() != 0 || exp_bytes.size() != 0) begin
      flush_missing();
    end
    $display("Errors: mismatch=%0d missing=%0d unexpected=%0d assertion=%0d",
             mismatch_cnt, missing_cnt, unexpected_cnt, assert_fails);
  endtask

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic gmii_rx_clk,
  output logic rst_n
);

  localparam int PERIOD_NS    = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    gmii_rx_clk = 1'b0;
    forever #(PERIOD_NS / 2) gmii_rx_clk = ~gmii_rx_clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge gmii_rx_clk);
    rst_n <= 1'b1;   // released on an edge, like the stimulus
  end

endmodule

`default_nettype wire

// ==== rtl/udp_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_top (
  input  wire                           gmii_rx_clk,
  input  wire                           rst_n,
  input  wire                           gmii_rxdv_i,
  input  wire  [udp_rx_pkg::BYTE_W-1:0] gmii_rxd_i,
  input  wire  [udp_rx_pkg::MAC_W-1:0]  local_mac_i,
  input  wire  [udp_rx_pkg::IP_W-1:0]   local_ip_i,
  input  wire  [udp_rx_pkg::PORT_W-1:0] local_port_i,
  output logic [udp_rx_pkg::BYTE_W-1:0] payload_data_o,
  output logic                          payload_valid_o,
  output logic                          pkt_done_o,
  output logic                          pkt_error_o,
  output logic [udp_rx_pkg::MAC_W-1:0]  src_mac_o,
  output logic [udp_rx_pkg::IP_W-1:0]   src_ip_o,
  output logic [udp_rx_pkg::PORT_W-1:0] src_port_o,
  output logic [udp_rx_pkg::PORT_W-1:0] payload_len_o
);

  rx_byte_if  rx_byte ();   // aligner -> parser, output stage
  rx_parse_if rx_parse ();  // parser -> output stage

  gmii_rx_align u_align (
    .gmii_rx_clk (gmii_rx_clk),
    .rst_n       (rst_n),
    .gmii_rxdv_i (gmii_rxdv_i),
    .gmii_rxd_i  (gmii_rxd_i),
    .byte_o      (rx_byte)
  );

  udp_hdr_parser u_parser (
    .gmii_rx_clk  (gmii_rx_clk),
    .rst_n        (rst_n),
    .local_mac_i  (local_mac_i),
    .local_ip_i   (local_ip_i),
    .local_port_i (local_port_i),
    .byte_i       (rx_byte),
    .parse_o      (rx_parse)
  );

  udp_rx_output u_output (
    .gmii_rx_clk     (gmii_rx_clk),
    .rst_n           (rst_n),
    .byte_i          (rx_byte),
    .parse_i         (rx_parse),
    .payload_data_o  (payload_data_o),
    .payload_valid_o (payload_valid_o),
    .pkt_done_o      (pkt_done_o),
    .pkt_error_o     (pkt_error_o),
    .src_mac_o       (src_mac_o),
    .src_ip_o        (src_ip_o),
    .src_port_o      (src_port_o),
    .payload_len_o   (payload_len_o)
  );

endmodule

`default_nettype wire

// ==== rtl/udp_rx_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_output (
  input  wire                           gmii_rx_clk,
  input  wire                           rst_n,
  rx_byte_if.dst                        byte_i,
  rx_parse_if.dst                       parse_i,
  output logic [udp_rx_pkg::BYTE_W-1:0] payload_data_o,
  output logic                          payload_valid_o,
  output logic                          pkt_done_o,
  output logic                          pkt_error_o,
  output logic [udp_rx_pkg::MAC_W-1:0]  src_mac_o,
  output logic [udp_rx_pkg::IP_W-1:0]   src_ip_o,
  output logic [udp_rx_pkg::PORT_W-1:0] src_port_o,
  output logic [udp_rx_pkg::PORT_W-1:0] payload_len_o
);

  logic [31:0] crc_q;
  logic [31:0] crc_next;
  logic        acc_q;
  logic        frame_end;   // last byte of an accepted frame

  // ------------------------------------------------------------------
  // crc-32 over sof..last, fcs included
  always_comb begin
    crc_next = byte_i.sof ? '1 : crc_q;
    for (int i = 0; i < udp_rx_pkg::BYTE_W; i++) begin
      if (crc_next[31] ^ byte_i.data[i]) begin
        crc_next = {crc_next[30:0], 1'b0} ^ udp_rx_pkg::CRC_POLY;
      end else begin
        crc_next = {crc_next[30:0], 1'b0};
      end
    end
  end

  assign frame_end = byte_i.valid & byte_i.last & parse_i.accepted;

  always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      crc_q           <= '1;
      payload_valid_o <= 1'b0;
      payload_data_o  <= '0;
      pkt_done_o      <= 1'b0;
      pkt_error_o     <= 1'b0;
    end else begin
      if (byte_i.valid) begin
        crc_q <= crc_next;
      end
      payload_valid_o <= parse_i.payload_sel;   // already qualified by valid
      if (parse_i.payload_sel) begin
        payload_data_o <= byte_i.data;
      end
      pkt_done_o  <= frame_end;
      pkt_error_o <= frame_end & (crc_next != udp_rx_pkg::CRC_RESIDUE);
    end
  end

  // source fields latched when a frame gets accepted
  always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q         <= 1'b0;
      src_mac_o     <= '0;
      src_ip_o      <= '0;
      src_port_o    <= '0;
      payload_len_o <= '0;
    end else begin
      acc_q <= parse_i.accepted;
      if (parse_i.accepted && !acc_q) begin
        src_mac_o     <= parse_i.src_mac;
        src_ip_o      <= parse_i.src_ip;
        src_port_o    <= parse_i.src_port;
        payload_len_o <= parse_i.payload_len;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/udp_hdr_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_hdr_parser (
  input  wire                          gmii_rx_clk,
  input  wire                          rst_n,
  input  wire [udp_rx_pkg::MAC_W-1:0]  local_mac_i,
  input  wire [udp_rx_pkg::IP_W-1:0]   local_ip_i,
  input  wire [udp_rx_pkg::PORT_W-1:0] local_port_i,
  rx_byte_if.dst                       byte_i,
  rx_parse_if.src                      parse_o
);

  logic [15:0]                   ofs_q;
  logic [15:0]                   ofs;      // offset of the current byte
  logic [4:0]                    ip_idx;   // byte index inside the ip header
  logic [udp_rx_pkg::MAC_W-1:0]  dst_mac;
  logic [udp_rx_pkg::MAC_W-1:0]  src_mac;
  logic [15:0]                   eth_type;
  udp_rx_pkg::ip_hdr_u           ip_hdr;
  logic [udp_rx_pkg::PORT_W-1:0] src_port;
  logic [udp_rx_pkg::PORT_W-1:0] dst_port;
  logic [udp_rx_pkg::PORT_W-1:0] payload_len;
  logic                          accepted;
  logic [19:0]                   csum_acc;
  logic [16:0]                   csum_fold;
  logic [15:0]                   csum;
  logic                          hdr_ok;

  // ------------------------------------------------------------------
  // byte offset counter
  assign ofs    = byte_i.sof ? '0 : ofs_q;
  assign ip_idx = 5'(ofs - 16'(udp_rx_pkg::IP_OFS));

  always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      ofs_q <= '0;
    end else if (byte_i.valid && ofs != '1) begin
      ofs_q <= ofs + 16'd1;
    end
  end

  // ------------------------------------------------------------------
  // header capture, fields shift in msb first
  always_ff @(posedge gmii_rx_clk) begin
    if (byte_i.valid) begin
      if (ofs < 16'(udp_rx_pkg::MAC_SRC_OFS)) begin
        dst_mac <= {dst_mac[udp_rx_pkg::MAC_W-udp_rx_pkg::BYTE_W-1:0], byte_i.data};
      end else if (ofs < 16'(udp_rx_pkg::ETH_TYPE_OFS)) begin
        src_mac <= {src_mac[udp_rx_pkg::MAC_W-udp_rx_pkg::BYTE_W-1:0], byte_i.data};
      end else if (ofs < 16'(udp_rx_pkg::IP_OFS)) begin
        eth_type <= {eth_type[7:0], byte_i.data};
      end else if (ofs < 16'(udp_rx_pkg::UDP_OFS)) begin
        if (ip_idx[0]) begin
          ip_hdr.words[4'd9 - ip_idx[4:1]][7:0] <= byte_i.data;   // low byte
        end else begin
          ip_hdr.words[4'd9 - ip_idx[4:1]][15:8] <= byte_i.data;
        end
      end else if (ofs < 16'(udp_rx_pkg::UDP_OFS + 2)) begin
        src_port <= {src_port[7:0], byte_i.data};
      end else if (ofs < 16'(udp_rx_pkg::UDP_OFS + 4)) begin
        dst_port <= {dst_port[7:0], byte_i.data};
      end
    end
  end

  // one's complement sum over the whole header, all ones when intact
  always_comb begin
    csum_acc = '0;
    for (int i = 0; i < 10; i++) begin
      csum_acc = csum_acc + 20'(ip_hdr.words[i]);
    end
    csum_fold = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
    csum      = csum_fold[15:0] + 16'(csum_fold[16]);
  end

  assign hdr_ok = (dst_mac == local_mac_i || dst_mac == udp_rx_pkg::BROADCAST_MAC) &&
                  eth_type == udp_rx_pkg::ETH_TYPE_IPV4 &&
                  ip_hdr.fields.version == udp_rx_pkg::IP_VERSION &&
                  ip_hdr.fields.ihl == udp_rx_pkg::IP_IHL &&
                  ip_hdr.fields.protocol == udp_rx_pkg::IP_PROTO_UDP &&
                  ip_hdr.fields.dst_ip == local_ip_i &&
                  csum == 16'hFFFF &&
                  dst_port == local_port_i;

  // ------------------------------------------------------------------
  // verdict, decided on the last udp header byte
  always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      accepted <= 1'b0;
    end else if (byte_i.valid) begin
      if (byte_i.sof) begin
        accepted <= 1'b0;
      end else if (ofs == 16'(udp_rx_pkg::PAYLOAD_OFS - 1)) begin
        accepted <= hdr_ok;
      end
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    if (byte_i.valid && ofs == 16'(udp_rx_pkg::PAYLOAD_OFS - 1)) begin
      payload_len <= ip_hdr.fields.total_len -
                     16'(udp_rx_pkg::IP_HDR_BYTES + udp_rx_pkg::UDP_HDR_BYTES);
    end
  end

  // padding and fcs fall outside this window
  assign parse_o.payload_sel = byte_i.valid && accepted &&
                               ofs >= 16'(udp_rx_pkg::PAYLOAD_OFS) &&
                               {1'b0, ofs} < {1'b0, payload_len} +
                                             17'(udp_rx_pkg::PAYLOAD_OFS);
  assign parse_o.accepted    = accepted;
  assign parse_o.src_mac     = src_mac;
  assign parse_o.src_ip      = ip_hdr.fields.src_ip;
  assign parse_o.src_port    = src_port;
  assign parse_o.payload_len = payload_len;

endmodule

`default_nettype wire

// ==== rtl/gmii_rx_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_align (
  input  wire                          gmii_rx_clk,
  input  wire                          rst_n,
  input  wire                          gmii_rxdv_i,
  input  wire [udp_rx_pkg::BYTE_W-1:0] gmii_rxd_i,
  rx_byte_if.src                       byte_o
);

  logic                          rxdv_q;    // first stage, one byte ahead
  logic                          rxdv_d;
  logic [udp_rx_pkg::BYTE_W-1:0] rxd_q;
  logic [udp_rx_pkg::BYTE_W-1:0] rxd_d;
  logic [3:0]                    pre_cnt;   // saturates at PREAMBLE_MIN
  logic                          in_frame;
  logic                          drop;      // bad burst, wait for dv low
  logic                          first;

  // ------------------------------------------------------------------
  // input registers
  always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      rxdv_q <= 1'b0;
      rxdv_d <= 1'b0;
    end else begin
      rxdv_q <= gmii_rxdv_i;
      rxdv_d <= rxdv_q;
    end
  end

  always_ff @(posedge gmii_rx_clk) begin
    rxd_q <= gmii_rxd_i;
    rxd_d <= rxd_q;
  end

  // ------------------------------------------------------------------
  // preamble and sfd search, runs on the second stage
  always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt  <= '0;
      in_frame <= 1'b0;
      drop     <= 1'b0;
      first    <= 1'b0;
    end else if (!rxdv_d) begin   // gap between bursts
      pre_cnt  <= '0;
      in_frame <= 1'b0;
      drop     <= 1'b0;
      first    <= 1'b0;
    end else if (in_frame) begin
      first <= 1'b0;
    end else if (!drop) begin
      if (rxd_d == udp_rx_pkg::PREAMBLE_BYTE) begin
        if (pre_cnt != 4'(udp_rx_pkg::PREAMBLE_MIN)) begin
          pre_cnt <= pre_cnt + 4'd1;
        end
      end else if (rxd_d == udp_rx_pkg::SFD_BYTE &&
                   pre_cnt == 4'(udp_rx_pkg::PREAMBLE_MIN)) begin
        in_frame <= 1'b1;
        first    <= 1'b1;
      end else begin
        drop <= 1'b1;   // short preamble or junk
      end
    end
  end

  // last comes from the byte behind still having dv high
  assign byte_o.data  = rxd_d;
  assign byte_o.valid = in_frame & rxdv_d;
  assign byte_o.sof   = in_frame & rxdv_d & first;
  assign byte_o.last  = in_frame & rxdv_d & ~rxdv_q;

endmodule

`default_nettype wire

// ==== rtl/rx_parse_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rx_parse_if;

  logic                          payload_sel;  // current byte is payload to forward
  logic                          accepted;     // held until next sof
  logic [udp_rx_pkg::MAC_W-1:0]  src_mac;
  logic [udp_rx_pkg::IP_W-1:0]   src_ip;
  logic [udp_rx_pkg::PORT_W-1:0] src_port;
  logic [udp_rx_pkg::PORT_W-1:0] payload_len;

  modport src (output payload_sel, accepted, src_mac, src_ip, src_port, payload_len);
  modport dst (input payload_sel, accepted, src_mac, src_ip, src_port, payload_len);

endinterface

`default_nettype wire

// ==== rtl/rx_byte_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// aligned frame bytes, one per cycle, no back-pressure
interface rx_byte_if;

  logic [udp_rx_pkg::BYTE_W-1:0] data;   // preamble and sfd already stripped
  logic                          valid;
  logic                          sof;    // first byte after the sfd
  logic                          last;   // last fcs byte

  modport src (output data, valid, sof, last);
  modport dst (input data, valid, sof, last);

endinterface

`default_nettype wire

// ==== rtl/udp_rx_pkg.sv ====
`default_nettype none

package udp_rx_pkg;

  // ------------------------------------------------------------------
  // widths
  localparam int BYTE_W = 8;
  localparam int MAC_W  = 48;
  localparam int IP_W   = 32;
  localparam int PORT_W = 16;

  // ------------------------------------------------------------------
  // protocol constants
  localparam logic [BYTE_W-1:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [BYTE_W-1:0] SFD_BYTE      = 8'hD5;
  localparam int                PREAMBLE_MIN  = 6;     // 0x55 bytes needed before sfd

  localparam logic [15:0]      ETH_TYPE_IPV4 = 16'h0800;
  localparam logic [MAC_W-1:0] BROADCAST_MAC = '1;
  localparam logic [3:0]       IP_VERSION    = 4'd4;
  localparam logic [3:0]       IP_IHL        = 4'd5;   // no options
  localparam logic [7:0]       IP_PROTO_UDP  = 8'd17;

  // ------------------------------------------------------------------
  // byte offsets, counted from the first byte after the sfd
  localparam int ETH_HDR_BYTES = 14;
  localparam int IP_HDR_BYTES  = 20;
  localparam int UDP_HDR_BYTES = 8;
  localparam int MAC_SRC_OFS   = 6;
  localparam int ETH_TYPE_OFS  = 12;
  localparam int IP_OFS        = ETH_HDR_BYTES;
  localparam int UDP_OFS       = IP_OFS + IP_HDR_BYTES;
  localparam int PAYLOAD_OFS   = UDP_OFS + UDP_HDR_BYTES;  // 42

  // crc-32 kept msb first, each byte fed lsb first
  localparam logic [31:0] CRC_POLY    = 32'h04C1_1DB7;
  localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

  // ipv4 header, read as named fields or as ten checksum words
  typedef union packed {
    struct packed {
      logic [3:0]      version;
      logic [3:0]      ihl;
      logic [7:0]      tos;
      logic [15:0]     total_len;
      logic [15:0]     id;
      logic [15:0]     flags_frag;
      logic [7:0]      ttl;
      logic [7:0]      protocol;
      logic [15:0]     checksum;
      logic [IP_W-1:0] src_ip;
      logic [IP_W-1:0] dst_ip;
    } fields;
    logic [9:0][15:0] words;   // words[9] is the first on the wire
  } ip_hdr_u;

endpackage

`default_nettype wire
